// ==== swi_consts.svh ====
// ======================================================================
// Sizing constants shared by the stack-machine core and its memory
// ======================================================================
`ifndef SWI_CONSTS_SVH
`define SWI_CONSTS_SVH

// Machine word
`define SWI_XLEN 32

// On-chip word memory, 4 KiB
`define SWI_MEM_WORDS 1024

// Word address width, taken from byte address bits 11:2
`define SWI_AW 10

// Stack starts at the top word of memory and grows down
`define SWI_SP_INIT 32'h0000_0FFC

// Immediate field above the opcode byte
`define SWI_IMM_W 24

`endif

// ==== swi_isa_pkg.sv ====
// ======================================================================
// Instruction set types: opcodes, instruction word, ALU operations
// ======================================================================
`include "swi_consts.svh"

package swi_isa_pkg;

  // Kept subset, numbered as in the Swieros emulator
  typedef enum logic [7:0] {
    OP_HALT = 8'd0,   OP_ENT  = 8'd1,   OP_LEV  = 8'd2,   OP_JMP  = 8'd3,
    OP_JSR  = 8'd5,                                   // Subroutine call
    OP_LL   = 8'd14,  OP_LG   = 8'd21,                // Word loads into A
    OP_LI   = 8'd35,  OP_LHI  = 8'd36,
    OP_LBI  = 8'd59,  OP_LBA  = 8'd62,
    OP_SL   = 8'd64,  OP_SG   = 8'd69,                // Word stores from A
    OP_ADD  = 8'd83,  OP_ADDI = 8'd84,
    OP_SUB  = 8'd86,  OP_SUBI = 8'd87,
    OP_MUL  = 8'd89,  OP_MULI = 8'd90,
    OP_AND  = 8'd104, OP_ANDI = 8'd105,
    OP_OR   = 8'd107, OP_ORI  = 8'd108,
    OP_XOR  = 8'd110, OP_XORI = 8'd111,
    OP_SHL  = 8'd113, OP_SHLI = 8'd114,
    OP_SHR  = 8'd116, OP_SHRI = 8'd117,               // Arithmetic right shift
    OP_SRU  = 8'd119, OP_SRUI = 8'd120,               // Logical right shift
    OP_EQ   = 8'd122, OP_NE   = 8'd124,
    OP_LT   = 8'd126, OP_LTU  = 8'd127,
    OP_GE   = 8'd129, OP_GEU  = 8'd130,
    OP_BZ   = 8'd132, OP_BNZ  = 8'd134,
    OP_BE   = 8'd136, OP_BNE  = 8'd138,
    OP_BLT  = 8'd140, OP_BGE  = 8'd143,
    OP_PSHA = 8'd157, OP_PSHB = 8'd160,
    OP_POPB = 8'd161, OP_POPA = 8'd163,
    OP_LCA  = 8'd173,
    OP_PUTC = 8'd240                                  // Character out, emulator extension
  } opcode_e;

  // Sign-extended immediate sits above the opcode byte
  typedef struct packed {
    logic [`SWI_IMM_W-1:0] imm;
    opcode_e               op;
  } instr_t;

  // Operation selected by the core for the shared ALU
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_MUL,
    ALU_AND, ALU_OR,  ALU_XOR,
    ALU_SHL, ALU_SHR, ALU_SRU,
    ALU_EQ,  ALU_NE,                                  // Also BE/BNE and BZ/BNZ
    ALU_LT,  ALU_LTU,
    ALU_GE,  ALU_GEU
  } alu_op_e;

endpackage

// ==== swi_bus_pkg.sv ====
// ======================================================================
// Memory bus request and response, core FSM state encoding
// ======================================================================
`include "swi_consts.svh"

package swi_bus_pkg;

  // Core to memory, held by the core until answered
  typedef struct packed {
    logic                 valid;
    logic                 we;     // Write when set, read otherwise
    logic [`SWI_AW-1:0]   addr;   // Word address
    logic [`SWI_XLEN-1:0] wdata;
  } mem_req_t;

  // One cycle after a request is taken
  typedef struct packed {
    logic                 valid;  // Read data or write acknowledge
    logic [`SWI_XLEN-1:0] rdata;
  } mem_rsp_t;

  typedef enum logic [2:0] {
    ST_IDLE,     // Waiting for start
    ST_FETCH,    // Instruction request
    ST_DECODE,   // Instruction response into IR
    ST_EXEC1,
    ST_MEMWAIT,  // Data request and response
    ST_EXEC2,
    ST_HALT
  } core_state_e;

endpackage

// ==== swi_alu.sv ====
// ======================================================================
// Combinational ALU with compare outputs for the branch opcodes
// ======================================================================
`timescale 1ns/1ps
`include "swi_consts.svh"

module swi_alu (
  input  swi_isa_pkg::alu_op_e  i_op,
  input  logic [`SWI_XLEN-1:0]  i_a,
  input  logic [`SWI_XLEN-1:0]  i_b,
  output logic [`SWI_XLEN-1:0]  o_y,
  output logic                  o_take
);
  import swi_isa_pkg::*;

  logic signed [`SWI_XLEN-1:0] sa;
  logic signed [`SWI_XLEN-1:0] sb;
  logic                        cmp;  // Compare result, zero for other ops

  assign sa = i_a;
  assign sb = i_b;

  // Six compares, signed and unsigned
  always_comb begin
    case (i_op)
      ALU_EQ:  cmp = (i_a == i_b);
      ALU_NE:  cmp = (i_a != i_b);
      ALU_LT:  cmp = (sa < sb);
      ALU_LTU: cmp = (i_a < i_b);
      ALU_GE:  cmp = (sa >= sb);
      ALU_GEU: cmp = (i_a >= i_b);
      default: cmp = 1'b0;
    endcase
  end

  // Shift counts of 32 or more clear the word, or fill it with the sign for SHR
  always_comb begin
    case (i_op)
      ALU_ADD: o_y = i_a + i_b;
      ALU_SUB: o_y = i_a - i_b;
      ALU_MUL: o_y = i_a * i_b;  // Low word of the product
      ALU_AND: o_y = i_a & i_b;
      ALU_OR:  o_y = i_a | i_b;
      ALU_XOR: o_y = i_a ^ i_b;
      ALU_SHL: o_y = i_a << i_b;
      ALU_SHR: o_y = sa >>> i_b;
      ALU_SRU: o_y = i_a >> i_b;
      default: o_y = {{(`SWI_XLEN-1){1'b0}}, cmp};  // Compares give 0 or 1
    endcase
  end

  assign o_take = cmp;  // Branch condition

endmodule

// ==== swi_core.sv ====
// ======================================================================
// Stack-machine core: fetch, decode and execute FSM
// Registers A, B, C, PC, SP and IR, one shared ALU, PUTC strobe
// ======================================================================
`timescale 1ns/1ps
`include "swi_consts.svh"

module swi_core (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_start,
  input  logic [`SWI_XLEN-1:0]   i_entry_pc,
  input  swi_bus_pkg::mem_rsp_t  i_rsp,
  output swi_bus_pkg::mem_req_t  o_req,
  output logic                   o_tx_stb,
  output logic [7:0]             o_tx_data,
  output logic                   o_halted
);
  import swi_isa_pkg::*;
  import swi_bus_pkg::*;

  core_state_e          state;
  logic [`SWI_XLEN-1:0] a, b, c;
  logic [`SWI_XLEN-1:0] pc, sp;
  instr_t               ir;
  logic [`SWI_XLEN-1:0] imm;      // Sign-extended immediate
  logic [`SWI_XLEN-1:0] ea;       // Byte address of the data access
  logic [`SWI_XLEN-1:0] st_data;
  logic                 st_we;
  logic [`SWI_XLEN-1:0] ld_data;  // Captured in MEMWAIT, used in EXEC2
  alu_op_e              alu_op;
  logic [`SWI_XLEN-1:0] alu_b;
  logic [`SWI_XLEN-1:0] alu_y;
  logic                 alu_take;

  assign imm = {{(`SWI_XLEN-`SWI_IMM_W){ir.imm[`SWI_IMM_W-1]}}, ir.imm};

  // Register and immediate forms share an ALU op, branches reuse the compares
  always_comb begin
    case (ir.op)
      OP_SUB, OP_SUBI:       alu_op = ALU_SUB;
      OP_MUL, OP_MULI:       alu_op = ALU_MUL;
      OP_AND, OP_ANDI:       alu_op = ALU_AND;
      OP_OR, OP_ORI:         alu_op = ALU_OR;
      OP_XOR, OP_XORI:       alu_op = ALU_XOR;
      OP_SHL, OP_SHLI:       alu_op = ALU_SHL;
      OP_SHR, OP_SHRI:       alu_op = ALU_SHR;
      OP_SRU, OP_SRUI:       alu_op = ALU_SRU;
      OP_EQ, OP_BE, OP_BZ:   alu_op = ALU_EQ;
      OP_NE, OP_BNE, OP_BNZ: alu_op = ALU_NE;
      OP_LT, OP_BLT:         alu_op = ALU_LT;
      OP_LTU:                alu_op = ALU_LTU;
      OP_GE, OP_BGE:         alu_op = ALU_GE;
      OP_GEU:                alu_op = ALU_GEU;
      default:               alu_op = ALU_ADD;
    endcase
  end

  // Second operand: immediate, zero for BZ/BNZ, else B
  always_comb begin
    case (ir.op)
      OP_ADDI, OP_SUBI, OP_MULI, OP_ANDI, OP_ORI,
      OP_XORI, OP_SHLI, OP_SHRI, OP_SRUI: alu_b = imm;
      OP_BZ, OP_BNZ:                      alu_b = '0;
      default:                            alu_b = b;
    endcase
  end

  swi_alu u_alu (
    .i_op   (alu_op),
    .i_a    (a),
    .i_b    (alu_b),
    .o_y    (alu_y),
    .o_take (alu_take)
  );

  // Request stays up until its response, so a lost grant is simply retried
  always_comb begin
    o_req.valid = (state == ST_FETCH) ||
                  ((state == ST_DECODE || state == ST_MEMWAIT) && !i_rsp.valid);
    o_req.we    = (state == ST_MEMWAIT) && st_we;
    o_req.addr  = (state == ST_MEMWAIT) ? ea[`SWI_AW+1:2] : pc[`SWI_AW+1:2];
    o_req.wdata = st_data;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= ST_IDLE;
      o_tx_stb <= 1'b0;
      o_halted <= 1'b0;
    end else begin
      o_tx_stb <= 1'b0;  // One-cycle strobe
      case (state)
        ST_IDLE: begin
          if (i_start) begin
            pc    <= i_entry_pc;
            sp    <= `SWI_SP_INIT;
            a     <= '0;
            b     <= '0;
            c     <= '0;
            state <= ST_FETCH;
          end
        end
        ST_FETCH: state <= ST_DECODE;
        ST_DECODE: begin
          if (i_rsp.valid) begin
            ir    <= instr_t'(i_rsp.rdata);
            pc    <= pc + 32'd4;  // Relative targets use the next PC
            state <= ST_EXEC1;
          end
        end
        ST_EXEC1: begin
          state <= ST_FETCH;  // Unless a memory phase follows
          st_we <= 1'b0;
          case (ir.op)
            OP_ADD, OP_ADDI, OP_SUB, OP_SUBI, OP_MUL, OP_MULI,
            OP_AND, OP_ANDI, OP_OR, OP_ORI, OP_XOR, OP_XORI,
            OP_SHL, OP_SHLI, OP_SHR, OP_SHRI, OP_SRU, OP_SRUI,
            OP_EQ, OP_NE, OP_LT, OP_LTU, OP_GE, OP_GEU: a <= alu_y;
            OP_BZ, OP_BNZ, OP_BE, OP_BNE, OP_BLT, OP_BGE: begin
              if (alu_take)
                pc <= pc + imm;
            end
            OP_JMP: pc <= pc + imm;
            OP_ENT: sp <= sp + imm;  // Frame allocate or release
            OP_LI:  a <= imm;
            OP_LHI: a <= {a[`SWI_XLEN-`SWI_IMM_W-1:0], ir.imm};  // Shift in 24 more bits
            OP_LBA: b <= a;
            OP_LBI: b <= imm;
            OP_LCA: c <= a;
            OP_PUTC: begin
              o_tx_stb  <= 1'b1;
              o_tx_data <= a[7:0];
            end
            OP_LL, OP_LG, OP_SL, OP_SG: begin
              ea      <= ((ir.op == OP_LL) || (ir.op == OP_SL)) ? sp + imm : pc + imm;
              st_data <= a;
              st_we   <= (ir.op == OP_SL) || (ir.op == OP_SG);
              state   <= ST_MEMWAIT;
            end
            OP_PSHA, OP_PSHB, OP_JSR: begin  // Stack slots are 8 bytes apart
              sp      <= sp - 32'd8;
              ea      <= sp - 32'd8;
              st_we   <= 1'b1;
              state   <= ST_MEMWAIT;
              case (ir.op)
                OP_PSHA: st_data <= a;
                OP_PSHB: st_data <= b;
                default: st_data <= pc;  // Return address
              endcase
            end
            OP_POPA, OP_POPB: begin
              ea    <= sp;
              state <= ST_MEMWAIT;
            end
            OP_LEV: begin  // Drop the frame, then fetch the return PC
              sp    <= sp + imm;
              ea    <= sp + imm;
              state <= ST_MEMWAIT;
            end
            default: begin  // HALT and unknown opcodes
              o_halted <= 1'b1;
              state    <= ST_HALT;
            end
          endcase
        end
        ST_MEMWAIT: begin
          if (i_rsp.valid) begin
            ld_data <= i_rsp.rdata;
            state   <= ST_EXEC2;
          end
        end
        ST_EXEC2: begin
          state <= ST_FETCH;
          case (ir.op)
            OP_LL, OP_LG: a <= ld_data;
            OP_POPA: begin
              a  <= ld_data;
              sp <= sp + 32'd8;
            end
            OP_POPB: begin
              b  <= ld_data;
              sp <= sp + 32'd8;
            end
            OP_LEV: begin
              pc <= ld_data;
              sp <= sp + 32'd8;
            end
            OP_JSR: pc <= pc + imm;  // Return address already stacked
            default: ;  // Stores and pushes are done
          endcase
        end
        default: state <= ST_HALT;  // Held until reset
      endcase
    end
  end

endmodule

// ==== swi_mem.sv ====
// ======================================================================
// Shared word memory, program-load port has priority over the core
// ======================================================================
`timescale 1ns/1ps
`include "swi_consts.svh"

module swi_mem (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  swi_bus_pkg::mem_req_t  i_req,
  input  logic                   i_ld_we,
  input  logic [`SWI_AW-1:0]     i_ld_addr,
  input  logic [`SWI_XLEN-1:0]   i_ld_data,
  output swi_bus_pkg::mem_rsp_t  o_rsp
);

  logic [`SWI_XLEN-1:0] mem [`SWI_MEM_WORDS];
  logic                 core_take;  // Core request granted this cycle
  logic                 rsp_valid;
  logic [`SWI_XLEN-1:0] rsp_data;

  // A load write steals the cycle, the core keeps requesting
  assign core_take = i_req.valid && !i_ld_we;

  // Single write port
  always_ff @(posedge i_clk) begin
    if (i_ld_we)
      mem[i_ld_addr] <= i_ld_data;
    else if (core_take && i_req.we)
      mem[i_req.addr] <= i_req.wdata;
  end

  // Read data, old contents on a write
  always_ff @(posedge i_clk) begin
    if (core_take)
      rsp_data <= mem[i_req.addr];
  end

  always_ff @(posedge i_clk) begin
    if (i_rst)
      rsp_valid <= 1'b0;
    else
      rsp_valid <= core_take;  // Exactly one cycle after the grant
  end

  assign o_rsp = '{valid: rsp_valid, rdata: rsp_data};

endmodule

// ==== swi_top.sv ====
// ======================================================================
// Top level: core and shared memory with the program-load port
// ======================================================================
`timescale 1ns/1ps
`include "swi_consts.svh"

module swi_top (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_start,
  input  logic [`SWI_XLEN-1:0] i_entry_pc,
  input  logic                 i_ld_we,    // One word per cycle
  input  logic [`SWI_AW-1:0]   i_ld_addr,
  input  logic [`SWI_XLEN-1:0] i_ld_data,
  output logic                 o_tx_stb,
  output logic [7:0]           o_tx_data,
  output logic                 o_halted
);
  import swi_bus_pkg::*;

  mem_req_t core_req;
  mem_rsp_t mem_rsp;

  swi_core u_core (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_start    (i_start),
    .i_entry_pc (i_entry_pc),
    .i_rsp      (mem_rsp),
    .o_req      (core_req),
    .o_tx_stb   (o_tx_stb),
    .o_tx_data  (o_tx_data),
    .o_halted   (o_halted)
  );

  swi_mem u_mem (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_req     (core_req),
    .i_ld_we   (i_ld_we),
    .i_ld_addr (i_ld_addr),
    .i_ld_data (i_ld_data),
    .o_rsp     (mem_rsp)
  );

endmodule

// ==== swi_assert.sv ====
// ======================================================================
// Bound assertions: memory arbitration, tx strobe, sticky halt
// ======================================================================
`timescale 1ns/1ps
`include "swi_consts.svh"

module swi_assert (
  input logic                  i_clk,
  input logic                  i_rst,
  input swi_bus_pkg::mem_req_t i_req,
  input swi_bus_pkg::mem_rsp_t i_rsp,
  input logic                  i_ld_we,
  input logic                  i_tx_stb,
  input logic                  i_halted
);

  // Load write owns the memory, no answer to the core next cycle
  a_ld_blocks: assert property (@(posedge i_clk) disable iff (i_rst)
    i_ld_we |=> !i_rsp.valid)
    else $error("core answered after a load-port write");

  a_rsp_next: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_req.valid && !i_ld_we) |=> i_rsp.valid)
    else $error("taken request without response one cycle later");

  a_rsp_only: assert property (@(posedge i_clk) disable iff (i_rst)
    i_rsp.valid |-> $past(i_req.valid && !i_ld_we))
    else $error("response without a taken request");

  a_tx_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
    i_tx_stb |=> !i_tx_stb)
    else $error("tx strobe high for two cycles");

  a_halt_sticky: assert property (@(posedge i_clk) disable iff (i_rst)
    i_halted |=> i_halted)
    else $error("halted fell without reset");

endmodule

// Top level holds both the core request and the memory response
bind swi_top swi_assert u_assert (
  .i_clk    (i_clk),
  .i_rst    (i_rst),
  .i_req    (core_req),
  .i_rsp    (mem_rsp),
  .i_ld_we  (i_ld_we),
  .i_tx_stb (o_tx_stb),
  .i_halted (o_halted)
);

// ==== tb_swi.sv ====
// ======================================================================
// Testbench for swi_top: random program generator, instruction-level
// reference model, load-port stall stimulus and result report
// ======================================================================
`timescale 1ns/1ps
`include "swi_consts.svh"

module tb_swi;
  import swi_isa_pkg::*;

  logic                 i_clk;
  logic                 i_rst;
  logic                 i_start;
  logic [`SWI_XLEN-1:0] i_entry_pc;
  logic                 i_ld_we;
  logic [`SWI_AW-1:0]   i_ld_addr;
  logic [`SWI_XLEN-1:0] i_ld_data;
  logic                 o_tx_stb;
  logic [7:0]           o_tx_data;
  logic                 o_halted;

  integer      seed = 84;
  int          n_tests = 0;
  int          n_checks = 0;
  int          n_errors = 0;
  int          n;                      // Words emitted so far
  logic [31:0] prog [`SWI_MEM_WORDS];  // Program image
  logic [31:0] mmem [`SWI_MEM_WORDS];  // Model memory
  logic [31:0] ldw [8];                // Words sent through the load port
  logic [7:0]  exp_q [$];
  logic [7:0]  got_q [$];
  logic        model_halted;

  opcode_e alu_ops [18] = '{OP_ADD, OP_ADDI, OP_SUB, OP_SUBI, OP_MUL, OP_MULI,
                            OP_AND, OP_ANDI, OP_OR, OP_ORI, OP_XOR, OP_XORI,
                            OP_SHL, OP_SHLI, OP_SHR, OP_SHRI, OP_SRU, OP_SRUI};
  opcode_e cmp_ops [6] = '{OP_EQ, OP_NE, OP_LT, OP_LTU, OP_GE, OP_GEU};
  opcode_e br_ops [6]  = '{OP_BZ, OP_BNZ, OP_BE, OP_BNE, OP_BLT, OP_BGE};

  swi_top u_dut (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_start    (i_start),
    .i_entry_pc (i_entry_pc),
    .i_ld_we    (i_ld_we),
    .i_ld_addr  (i_ld_addr),
    .i_ld_data  (i_ld_data),
    .o_tx_stb   (o_tx_stb),
    .o_tx_data  (o_tx_data),
    .o_halted   (o_halted)
  );

  initial i_clk = 1'b0;
  always #50 i_clk = ~i_clk;  // 100 ns period

  // Registered outputs, sampled at the rising edge
  always @(posedge i_clk) begin
    if (o_tx_stb)
      got_q.push_back(o_tx_data);
  end

  function automatic logic [31:0] rnd(input logic [31:0] mask);
    return $random(seed) & mask;
  endfunction

  function automatic int pick(input int lim);
    return int'(($random(seed) & 32'h7fff_ffff) % lim);
  endfunction

  function automatic void emit(input opcode_e op, input logic [31:0] imm);
    prog[n] = {imm[`SWI_IMM_W-1:0], op};
    n++;
  endfunction

  // PC-relative target, counted from the word after the instruction
  function automatic void emit_rel(input opcode_e op, input logic [31:0] target);
    emit(op, target - 32'(4 * (n + 1)));
  endfunction

  function automatic bit is_imm_form(input opcode_e op);
    case (op)
      OP_ADDI, OP_SUBI, OP_MULI, OP_ANDI, OP_ORI,
      OP_XORI, OP_SHLI, OP_SHRI, OP_SRUI: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic bit is_shift(input opcode_e op);
    return op inside {OP_SHL, OP_SHLI, OP_SHR, OP_SHRI, OP_SRU, OP_SRUI};
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Reference interpreter, one instruction per loop pass
  task automatic run_model(input logic [31:0] entry);
    logic [31:0] pc, sp, a, b, c, imm, ins, s;
    int          steps;
    bit          done;
    pc = entry;
    sp = `SWI_SP_INIT;
    a = 0;
    b = 0;
    c = 0;
    done = 0;
    steps = 0;
    exp_q.delete();
    while (!done && steps < 20000) begin
      ins = mmem[pc[11:2]];
      imm = {{8{ins[31]}}, ins[31:8]};
      pc = pc + 32'd4;
      s = is_imm_form(opcode_e'(ins[7:0])) ? imm : b;  // Second operand
      steps++;
      case (ins[7:0])
        OP_ADD, OP_ADDI: a = a + s;
        OP_SUB, OP_SUBI: a = a - s;
        OP_MUL, OP_MULI: a = a * s;
        OP_AND, OP_ANDI: a = a & s;
        OP_OR, OP_ORI:   a = a | s;
        OP_XOR, OP_XORI: a = a ^ s;
        OP_SHL, OP_SHLI: a = (s >= 32) ? 32'd0 : a << s[4:0];
        OP_SHR, OP_SHRI: begin  // Sign fill
          if (s >= 32)
            a = {32{a[31]}};
          else
            a = $signed(a) >>> s[4:0];
        end
        OP_SRU, OP_SRUI: a = (s >= 32) ? 32'd0 : a >> s[4:0];
        OP_EQ:   a = {31'd0, a == b};
        OP_NE:   a = {31'd0, a != b};
        OP_LT:   a = {31'd0, $signed(a) < $signed(b)};
        OP_LTU:  a = {31'd0, a < b};
        OP_GE:   a = {31'd0, $signed(a) >= $signed(b)};
        OP_GEU:  a = {31'd0, a >= b};
        OP_BZ:   if (a == 0) pc = pc + imm;
        OP_BNZ:  if (a != 0) pc = pc + imm;
        OP_BE:   if (a == b) pc = pc + imm;
        OP_BNE:  if (a != b) pc = pc + imm;
        OP_BLT:  if ($signed(a) < $signed(b)) pc = pc + imm;
        OP_BGE:  if ($signed(a) >= $signed(b)) pc = pc + imm;
        OP_JMP:  pc = pc + imm;
        OP_LI:   a = imm;
        OP_LHI:  a = {a[7:0], ins[31:8]};
        OP_LBA:  b = a;
        OP_LBI:  b = imm;
        OP_LCA:  c = a;
        OP_LL:   a = mmem[(sp + imm) >> 2];
        OP_LG:   a = mmem[(pc + imm) >> 2];
        OP_SL:   mmem[(sp + imm) >> 2] = a;
        OP_SG:   mmem[(pc + imm) >> 2] = a;
        OP_ENT:  sp = sp + imm;
        OP_PSHA, OP_PSHB, OP_JSR: begin
          sp = sp - 32'd8;
          mmem[sp[11:2]] = (ins[7:0] == OP_PSHA) ? a : (ins[7:0] == OP_PSHB) ? b : pc;
          if (ins[7:0] == OP_JSR) pc = pc + imm;
        end
        OP_POPA, OP_POPB, OP_LEV: begin
          if (ins[7:0] == OP_LEV) sp = sp + imm;
          if (ins[7:0] == OP_POPA) a = mmem[sp[11:2]];
          else if (ins[7:0] == OP_POPB) b = mmem[sp[11:2]];
          else pc = mmem[sp[11:2]];
          sp = sp + 32'd8;
        end
        OP_PUTC: exp_q.push_back(a[7:0]);
        default: done = 1;  // HALT or unknown opcode
      endcase
    end
    model_halted = done;
  endtask

  task automatic apply_reset();
    @(negedge i_clk);
    i_rst = 1'b1;
    repeat (2) @(negedge i_clk);
    i_rst = 1'b0;
  endtask

  task automatic load_program();
    for (int i = 0; i < n; i++) begin
      @(negedge i_clk);
      i_ld_we = 1'b1;
      i_ld_addr = i[`SWI_AW-1:0];
      i_ld_data = prog[i];
    end
    @(negedge i_clk);
    i_ld_we = 1'b0;
  endtask

  // Load program, start, optionally hammer the load port, wait for halt
  task automatic run_test(input string name, input bit stall);
    int cyc;
    int k;
    int errs_before;
    errs_before = n_errors;
    apply_reset();
    load_program();
    for (int i = 0; i < `SWI_MEM_WORDS; i++)
      mmem[i] = (i < n) ? prog[i] : 32'd0;
    for (int i = 0; i < 8; i++) begin
      ldw[i] = rnd(32'hffff_ffff);
      if (stall) mmem[768 + i] = ldw[i];
    end
    run_model(32'd0);
    got_q.delete();
    @(negedge i_clk);
    i_entry_pc = 32'd0;
    i_start = 1'b1;
    @(negedge i_clk);
    i_start = 1'b0;
    k = 0;
    cyc = 0;
    while (stall && k < 8 && cyc < 200) begin  // Random gaps between load writes
      @(negedge i_clk);
      i_ld_we = 1'b0;
      cyc++;
      if (pick(2) == 0) begin
        i_ld_we = 1'b1;
        i_ld_addr = 10'(768 + k);
        i_ld_data = ldw[k];
        k++;
      end
    end
    @(negedge i_clk);
    i_ld_we = 1'b0;
    cyc = 0;
    while (!o_halted && cyc < 10000) begin
      @(negedge i_clk);
      cyc++;
    end
    if (!o_halted) begin
      $display("Timeout: CPU did not halt in test %s", name);
      n_errors++;
    end
    repeat (20) @(negedge i_clk);  // Nothing may follow the halt
    check({name, " halt"}, 32'(model_halted), 32'(o_halted));
    check({name, " byte count"}, 32'(exp_q.size()), 32'(got_q.size()));
    for (int i = 0; i < exp_q.size() && i < got_q.size(); i++)
      check($sformatf("%s byte %0d", name, i), 32'(exp_q[i]), 32'(got_q[i]));
    n_tests++;
    $display("%s finished, %0d bytes, %s", name, got_q.size(),
             (n_errors == errs_before) ? "ok" : "errors");
  endtask

  task automatic gen_alu(input int count);
    opcode_e op;
    emit(OP_LI, rnd(32'hff_ffff));
    emit(OP_LHI, rnd(32'hff_ffff));
    emit(OP_LBA, 0);
    emit(OP_LBI, rnd(32'hff_ffff));
    repeat (count) begin
      op = alu_ops[pick(18)];
      if (pick(4) == 0) begin  // Fresh A so AND/MUL chains do not stick at zero
        emit(OP_LI, rnd(32'hff_ffff));
        emit(OP_LHI, rnd(32'hff_ffff));
      end
      if (!is_imm_form(op))
        emit(OP_LBI, is_shift(op) ? rnd(32'd63) : rnd(32'hff_ffff));
      emit(op, is_shift(op) ? rnd(32'd31) : rnd(32'hff_ffff));
      emit(OP_PUTC, 0);
    end
  endtask

  task automatic gen_branch(input int count);
    for (int i = 0; i < count; i++) begin
      emit(OP_LI, rnd(32'd7) - 32'd4);
      emit(OP_LBI, rnd(32'd7) - 32'd4);
      if (pick(2) == 0) begin
        emit(cmp_ops[pick(6)], 0);
        emit(OP_PUTC, 0);
      end else begin
        emit(br_ops[pick(6)], 32'd12);  // Taken path skips three words
        emit(OP_LI, 32'(8'h40 + i));
        emit(OP_PUTC, 0);
        emit(OP_JMP, 32'd8);
        emit(OP_LI, 32'(8'h60 + i));
        emit(OP_PUTC, 0);
      end
    end
    emit(OP_HALT, 0);
  endtask

  task automatic gen_stack();
    int jsr_at;
    emit(OP_ENT, -32'sd64);
    emit(OP_LI, rnd(32'hff_ffff));
    emit(OP_SL, 32'd16);
    emit(OP_LI, 0);
    emit(OP_LL, 32'd16);
    emit(OP_PUTC, 0);
    emit(OP_LI, rnd(32'hff_ffff));
    emit_rel(OP_SG, 32'h800);
    emit(OP_LI, 0);
    emit_rel(OP_LG, 32'h800);
    emit(OP_PUTC, 0);
    emit(OP_LI, rnd(32'hff_ffff));
    emit(OP_PSHA, 0);
    emit(OP_LBI, 0);
    emit(OP_POPB, 0);
    emit(OP_LI, 0);
    emit(OP_ADD, 0);  // A takes B
    emit(OP_PUTC, 0);
    emit(OP_LBI, rnd(32'hff_ffff));
    emit(OP_PSHB, 0);
    emit(OP_LI, 0);
    emit(OP_POPA, 0);
    emit(OP_PUTC, 0);
    emit(OP_LCA, 0);
    jsr_at = n;
    emit(OP_JSR, 0);  // Patched once the subroutine address is known
    emit(OP_LI, rnd(32'hff_ffff));
    emit(OP_PUTC, 0);
    emit(OP_ENT, 32'd64);
    emit(OP_HALT, 0);
    prog[jsr_at] = {24'(4 * (n - jsr_at - 1)), OP_JSR};
    emit(OP_ENT, -32'sd16);
    emit(OP_LI, rnd(32'hff_ffff));
    emit(OP_PUTC, 0);
    emit(OP_LEV, 32'd16);
  endtask

  initial begin
    i_rst = 1'b1;
    i_start = 1'b0;
    i_entry_pc = '0;
    i_ld_we = 1'b0;
    i_ld_addr = '0;
    i_ld_data = '0;

    apply_reset();
    got_q.delete();
    repeat (20) @(negedge i_clk);
    check("idle strobes", 32'd0, 32'(got_q.size()));
    check("idle halt", 32'd0, 32'(o_halted));
    n_tests++;
    $display("idle after reset finished");

    for (int t = 0; t < 3; t++) begin
      n = 0;
      gen_alu(16);
      emit(OP_HALT, 0);
      run_test($sformatf("alu_%0d", t), 1'b0);
    end
    for (int t = 0; t < 3; t++) begin
      n = 0;
      gen_branch(12);
      run_test($sformatf("branch_%0d", t), 1'b0);
    end
    for (int t = 0; t < 2; t++) begin
      n = 0;
      gen_stack();
      run_test($sformatf("stack_%0d", t), 1'b0);
    end

    n = 0;
    gen_alu(12);
    for (int k = 0; k < 8; k++) begin  // Read back every loaded word byte by byte
      emit_rel(OP_LG, 32'(32'hC00 + 4 * k));
      repeat (3) begin
        emit(OP_PUTC, 0);
        emit(OP_SRUI, 32'd8);
      end
      emit(OP_PUTC, 0);
    end
    emit(OP_HALT, 0);
    run_test("load_stall", 1'b1);

    n = 0;
    emit(OP_LI, rnd(32'hff_ffff));
    emit(OP_PUTC, 0);
    prog[n] = rnd(32'hffff_ff00) | 32'h0000_00FA;  // Opcode 250 is not defined
    n++;
    emit(OP_PUTC, 0);
    emit(OP_HALT, 0);
    run_test("unknown_op", 1'b0);

    $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+.
swi_isa_pkg.sv
swi_bus_pkg.sv
swi_alu.sv
swi_core.sv
swi_mem.sv
swi_top.sv
swi_assert.sv
tb_swi.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the stack-machine testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter project directory"
  exit 1
fi

verilator --binary --timing --assert -j 0 --top-module tb_swi -f src.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out="$(./obj_dir/Vtb_swi)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1
